//--- files.f
rtl/mskPkg.sv
rtl/nibbleFifo.sv
rtl/mskModulator.sv
rtl/phaseDetector.sv
rtl/clockRecovery.sv
rtl/mskModemTop.sv
test/mskModemTb.sv

//--- Makefile
# Verilator build and run of the MSK modem testbench

VERILATOR ?= verilator
TOP       ?= mskModemTb
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- test/mskModemTb.sv
`timescale 1ns/1ps
`default_nettype none

module mskModemTb;
	import mskPkg::*;

	localparam int SPB        = 4;
	localparam int DEPTH      = 8;
	localparam int CLK_PERIOD = 10;
	// Nibbles sent over all tests including the dropped input write
	localparam int TOTAL_NIBBLES   = 64 + 10 + (DEPTH + 1) + 4;
	localparam int WATCHDOG_CYCLES = TOTAL_NIBBLES * 4 * SPB + 200;

	typedef iqSample_t sampleQ_t [$];

	logic       clk;
	logic       rstN;
	logic       wrEn;
	nibble_t    wrData;
	logic       inFull;
	logic       rdEn;
	nibble_t    rdData;
	logic       rxEmpty;
	logic       testMode;
	iqSample_t  adcSample;
	logic       adcValid;
	obsSel_t    obsSel;
	obsWord_t   obs;

	nibble_t    expNibbles [$];
	iqSample_t  expSamples [$];
	int         refPhase;
	logic       readPending;
	string      testName;

	mskModemTop #(
		.SAMPLES_PER_BIT (SPB),
		.FIFO_DEPTH      (DEPTH)
	) u_dut (
		.i_clock     (clk),
		.i_rstN      (rstN),
		.i_wrEn      (wrEn),
		.i_wrData    (wrData),
		.o_inFull    (inFull),
		.i_rdEn      (rdEn),
		.o_rdData    (rdData),
		.o_rxEmpty   (rxEmpty),
		.i_testMode  (testMode),
		.i_adcSample (adcSample),
		.i_adcValid  (adcValid),
		.i_obsSel    (obsSel),
		.o_obs       (obs)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Wheel sine from the first quarter and its symmetry
	function automatic logic signed [3:0] wheelSin(input int idx);
		int quarter [5] = '{0, 3, 5, 6, 7};
		int k;
		int v;
		k = idx & 15;
		if (k <= 4)
			v = quarter[k];
		else if (k < 8)
			v = quarter[8 - k];
		else if (k < 12)
			v = -quarter[k - 8];
		else
			v = -quarter[16 - k];
		return 4'(v);
	endfunction

	// Samples of one nibble in MSB first order with one wheel step each
	function automatic sampleQ_t wheelSamples(input nibble_t n, inout int ph);
		sampleQ_t  q;
		iqSample_t s;
		int        step;
		step = 4 / SPB;
		for (int b = 3; b >= 0; b--) begin
			for (int i = 0; i < SPB; i++) begin
				ph = n[b] ? (ph + step) % 16 : (ph + 16 - step) % 16;
				s.sinI = wheelSin(ph + 4);
				s.sinQ = wheelSin(ph);
				q.push_back(s);
			end
		end
		return q;
	endfunction

	// Recovered data is just the sent nibbles in order
	function automatic nibble_t recoveredNibble(input nibble_t n);
		return n;
	endfunction

	function automatic void queueSamples(input nibble_t n);
		sampleQ_t q;
		q = wheelSamples(n, refPhase);
		foreach (q[i])
			expSamples.push_back(q[i]);
	endfunction

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkNibble(input string name, input nibble_t exp, input nibble_t act);
		if (act !== exp)
			abortRun($sformatf("** Error [%s] expected %h actual %h", name, exp, act));
	endtask

	task automatic checkSample(input string name, input iqSample_t exp, input iqSample_t act);
		if (act !== exp)
			abortRun($sformatf("** Error [%s] expected %h actual %h", name, exp, act));
	endtask

	task automatic checkStatus(input string name, input modStatus_t exp, input modStatus_t act);
		if (act !== exp)
			abortRun($sformatf("** Error [%s] expected %h actual %h", name, exp, act));
	endtask

	// Output FIFO read data is compared the cycle after the read
	always @(negedge clk) begin
		if (readPending) begin
			if (expNibbles.size() == 0)
				abortRun("output FIFO returned a nibble that was never sent");
			else
				checkNibble(testName, expNibbles.pop_front(), rdData);
		end
		readPending = rstN && rdEn && !rxEmpty;
	end

	// Modulator samples while it is busy
	always @(negedge clk) begin
		if (rstN && u_dut.txBusy) begin
			if (expSamples.size() == 0)
				abortRun("modulator sent a sample that was never expected");
			else if (obsSel == OBS_MOD_IQ)
				checkSample("modulator samples", expSamples.pop_front(), obs.sample);
			else
				abortRun("observation select moved while the modulator was busy");
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abortRun("watchdog expired before the tests finished");
	end

	////////////////////////////////////////
	// Drive helpers
	////////////////////////////////////////

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic writeNibble(input nibble_t n);
		wrEn   = 1'b1;
		wrData = n;
		step();
		wrEn   = 1'b0;
	endtask

	task automatic drainOne();
		while (rxEmpty)
			step();
		rdEn = 1'b1;
		step();
		rdEn = 1'b0;
	endtask

	// Modulator idle with nothing queued
	task automatic waitIdle();
		while (!(u_dut.inEmpty && !u_dut.txBusy))
			step();
	endtask

	task automatic sendLoopback();
		int      sent;
		int      burst;
		logic    spaced;
		nibble_t n;
		sent = 0;
		while (sent < 64) begin
			// First one is a lone nibble after an idle line
			burst  = (sent == 0) ? 1 : int'($urandom_range(6, 1));
			spaced = (sent == 0) || ($urandom_range(3) == 0);
			if (burst > 64 - sent)
				burst = 64 - sent;
			if (spaced) begin
				waitIdle();
				repeat ($urandom_range(3, 1)) step();
			end
			repeat (burst) begin
				while (inFull)
					step();
				n = nibble_t'($urandom);
				queueSamples(n);
				expNibbles.push_back(recoveredNibble(n));
				writeNibble(n);
				sent++;
			end
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		nibble_t    n;
		nibble_t    lastSent;
		nibble_t    held [$];
		nibble_t    injected [4];
		sampleQ_t   adcQ;
		sampleQ_t   part;
		modStatus_t expStat;
		int         adcPhase;

		clk         = 1'b0;
		rstN        = 1'b0;
		wrEn        = 1'b0;
		wrData      = '0;
		rdEn        = 1'b0;
		testMode    = 1'b0;
		adcSample   = '0;
		adcValid    = 1'b0;
		obsSel      = OBS_STATUS;
		refPhase    = 0;
		readPending = 1'b0;
		testName    = "reset";
		injected    = '{4'hA, 4'h5, 4'h3, 4'hC};
		void'($urandom(32'hf8cf));

		repeat (4) @(posedge clk);
		#1;
		rstN = 1'b1;
		step();

		testName = "status after reset";
		expStat  = '{inEmpty: 1'b1, outFull: 1'b0, txBusy: 1'b0, dir: 1'b0,
		             bitValid: 1'b0, testMode: 1'b0, spare: 2'b00};
		checkStatus(testName, expStat, obs.status);
		obsSel = OBS_MOD_IQ;

		testName = "loopback data";
		fork
			sendLoopback();
			repeat (64) drainOne();
		join

		// Fill the output FIFO with nobody reading
		testName = "output FIFO full";
		lastSent = '0;
		for (int i = 0; i < 10; i++) begin
			n = nibble_t'($urandom);
			queueSamples(n);
			if (i < DEPTH)
				expNibbles.push_back(recoveredNibble(n));
			while (inFull)
				step();
			writeNibble(n);
			lastSent = n;
		end
		waitIdle();
		repeat (6) step();
		obsSel  = OBS_STATUS;
		step();
		expStat = '{inEmpty: 1'b1, outFull: 1'b1, txBusy: 1'b0, dir: lastSent[0],
		            bitValid: 1'b0, testMode: 1'b0, spare: 2'b00};
		checkStatus(testName, expStat, obs.status);
		obsSel = OBS_MOD_IQ;
		repeat (DEPTH) drainOne();
		repeat (2) step();
		if (!rxEmpty)
			abortRun("output FIFO returned more nibbles than its depth");

		// Input FIFO fills up while the modulator is blocked
		testName = "input FIFO full";
		testMode = 1'b1;
		step();
		for (int i = 0; i < DEPTH; i++) begin
			n = nibble_t'($urandom);
			held.push_back(n);
			queueSamples(n);
			writeNibble(n);
		end
		if (!inFull)
			abortRun("input FIFO did not report full after a full set of writes");
		writeNibble(nibble_t'($urandom));

		// ADC samples with the first one missing
		testName = "external injection";
		adcPhase = 0;
		foreach (injected[i]) begin
			part = wheelSamples(injected[i], adcPhase);
			foreach (part[j])
				adcQ.push_back(part[j]);
			expNibbles.push_back(recoveredNibble(injected[i]));
		end
		void'(adcQ.pop_front());
		obsSel = OBS_ADC_IQ;
		foreach (adcQ[i]) begin
			adcSample = adcQ[i];
			adcValid  = 1'b1;
			step();
			checkSample(testName, adcQ[i], obs.sample);
		end
		adcValid = 1'b0;
		repeat (4) drainOne();

		// Last nibble read sits in the low half of the observation word
		obsSel = OBS_OUT_NIBBLE;
		step();
		checkNibble(testName, injected[3], nibble_t'(obs.sample.sinQ));
		obsSel = OBS_MOD_IQ;

		testName = "input FIFO full";
		foreach (held[i])
			expNibbles.push_back(recoveredNibble(held[i]));
		testMode = 1'b0;
		repeat (DEPTH) drainOne();
		waitIdle();
		repeat (6) step();
		if (!rxEmpty)
			abortRun("a nibble dropped at the full input FIFO came back");

		if (expNibbles.size() != 0 || expSamples.size() != 0) begin
			abortRun("expected nibbles or samples never arrived");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- rtl/mskModemTop.sv
`timescale 1ns/1ps
`default_nettype none

module mskModemTop #(
	parameter int SAMPLES_PER_BIT = 4,
	parameter int FIFO_DEPTH      = 8
) (
	input  wire                    i_clock,
	input  wire                    i_rstN,
	input  wire                    i_wrEn,
	input  wire mskPkg::nibble_t   i_wrData,
	output logic                   o_inFull,
	input  wire                    i_rdEn,
	output mskPkg::nibble_t        o_rdData,
	output logic                   o_rxEmpty,
	input  wire                    i_testMode,
	input  wire mskPkg::iqSample_t i_adcSample,
	input  wire                    i_adcValid,
	input  wire mskPkg::obsSel_t   i_obsSel,
	output mskPkg::obsWord_t       o_obs
);
	import mskPkg::*;

	logic       inEmpty;
	logic       inRdEn;
	nibble_t    inRdData;
	logic       modFifoEmpty;
	iqSample_t  modSample;
	logic       modValid;
	logic       txBusy;
	iqSample_t  detSample;
	logic       detValid;
	logic       dir;
	logic       dirValid;
	nibble_t    rxNibble;
	logic       rxValid;
	logic       outFull;
	modStatus_t status;

	////////////////////////////////////////
	// Transmit side
	////////////////////////////////////////

	nibbleFifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_inFifo (
		.i_clock  (i_clock),
		.i_rstN   (i_rstN),
		.i_wrEn   (i_wrEn),
		.i_wrData (i_wrData),
		.i_rdEn   (inRdEn),
		.o_rdData (inRdData),
		.o_empty  (inEmpty),
		.o_full   (o_inFull)
	);

	// Test mode starves the modulator so the input FIFO keeps its data
	assign modFifoEmpty = inEmpty || i_testMode;

	mskModulator #(.SAMPLES_PER_BIT(SAMPLES_PER_BIT)) u_modulator (
		.i_clock     (i_clock),
		.i_rstN      (i_rstN),
		.i_fifoEmpty (modFifoEmpty),
		.i_fifoData  (inRdData),
		.o_fifoRdEn  (inRdEn),
		.o_sample    (modSample),
		.o_valid     (modValid),
		.o_busy      (txBusy)
	);

	////////////////////////////////////////
	// Receive side
	////////////////////////////////////////

	// External ADC samples replace the loopback in test mode
	assign detSample = i_testMode ? i_adcSample : modSample;
	assign detValid  = i_testMode ? i_adcValid : modValid;

	phaseDetector u_phaseDetector (
		.i_clock    (i_clock),
		.i_rstN     (i_rstN),
		.i_sample   (detSample),
		.i_valid    (detValid),
		.o_dir      (dir),
		.o_dirValid (dirValid)
	);

	clockRecovery #(.SAMPLES_PER_BIT(SAMPLES_PER_BIT)) u_clockRecovery (
		.i_clock       (i_clock),
		.i_rstN        (i_rstN),
		.i_dir         (dir),
		.i_dirValid    (dirValid),
		.o_nibble      (rxNibble),
		.o_nibbleValid (rxValid)
	);

	nibbleFifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_outFifo (
		.i_clock  (i_clock),
		.i_rstN   (i_rstN),
		.i_wrEn   (rxValid),
		.i_wrData (rxNibble),
		.i_rdEn   (i_rdEn),
		.o_rdData (o_rdData),
		.o_empty  (o_rxEmpty),
		.o_full   (outFull)
	);

	////////////////////////////////////////
	// Observation port
	////////////////////////////////////////

	assign status = '{
		inEmpty:  inEmpty,
		outFull:  outFull,
		txBusy:   txBusy,
		dir:      dir,
		bitValid: dirValid,
		testMode: i_testMode,
		spare:    2'b00
	};

	always_comb begin
		o_obs = '0;
		case (i_obsSel)
			OBS_MOD_IQ:     o_obs.sample = modSample;
			OBS_ADC_IQ:     o_obs.sample = i_adcSample;
			OBS_STATUS:     o_obs.status = status;
			// Last nibble read from the output FIFO, in the low half
			OBS_OUT_NIBBLE: o_obs.sample.sinQ = o_rdData;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/clockRecovery.sv
`timescale 1ns/1ps
`default_nettype none

module clockRecovery #(
	parameter int SAMPLES_PER_BIT = 4
) (
	input  wire             i_clock,
	input  wire             i_rstN,
	input  wire             i_dir,
	input  wire             i_dirValid,
	output mskPkg::nibble_t o_nibble,
	output logic            o_nibbleValid
);
	import mskPkg::*;

	localparam int CNT_W = $clog2(SAMPLES_PER_BIT + 1);
	localparam logic [CNT_W-1:0] WIN_LAST = CNT_W'(SAMPLES_PER_BIT - 1);
	localparam logic [CNT_W-1:0] WIN_FULL = CNT_W'(SAMPLES_PER_BIT);

	logic [CNT_W-1:0] winCnt;
	logic [CNT_W-1:0] onesCnt;
	logic             lastDir;
	logic             holdWin;
	logic [1:0]       bitCnt;
	logic             reversal;
	logic             fullWin;
	logic             voteNow;
	logic [CNT_W-1:0] voteOnes;
	logic [CNT_W-1:0] voteTotal;
	logic             voteBit;

	////////////////////////////////////////
	// Window and vote
	////////////////////////////////////////

	// A turn inside a window marks a bit edge, so the window closes early
	assign reversal = i_dirValid && !holdWin && (winCnt != '0) && (i_dir != lastDir);
	assign fullWin  = i_dirValid && !reversal && (winCnt == WIN_LAST);
	// End of stream also flushes a partial window
	assign voteNow  = fullWin || ((winCnt != '0) && (reversal || !i_dirValid));

	always_comb begin
		if (fullWin) begin
			voteOnes  = onesCnt + CNT_W'(i_dir);
			voteTotal = WIN_FULL;
		end else begin
			voteOnes  = onesCnt;
			voteTotal = winCnt;
		end
		// Majority, ties go to one
		voteBit = {voteOnes, 1'b0} >= {1'b0, voteTotal};
	end

	always_ff @(posedge i_clock or negedge i_rstN) begin
		if (!i_rstN) begin
			winCnt        <= '0;
			onesCnt       <= '0;
			lastDir       <= 1'b0;
			holdWin       <= 1'b0;
			bitCnt        <= '0;
			o_nibbleValid <= 1'b0;
		end else begin
			o_nibbleValid <= voteNow && (bitCnt == 2'd3);
			if (!i_dirValid) begin
				winCnt  <= '0;
				onesCnt <= '0;
				holdWin <= 1'b0;
				bitCnt  <= '0;
			end else begin
				lastDir <= i_dir;
				if (voteNow) begin
					bitCnt <= bitCnt + 2'd1;
				end
				if (reversal) begin
					// Realign, then trust the new window to its end
					winCnt  <= CNT_W'(1);
					onesCnt <= CNT_W'(i_dir);
					holdWin <= 1'b1;
				end else if (fullWin) begin
					winCnt  <= '0;
					onesCnt <= '0;
					holdWin <= 1'b0;
				end else begin
					winCnt  <= winCnt + CNT_W'(1);
					onesCnt <= onesCnt + CNT_W'(i_dir);
				end
			end
		end
	end

	// Bit packer, first bit ends up in the MSB
	always_ff @(posedge i_clock) begin
		if (voteNow) begin
			o_nibble <= {o_nibble[2:0], voteBit};
		end
	end

	aNibblePulse: assert property (@(posedge i_clock) disable iff (!i_rstN)
		o_nibbleValid |=> !o_nibbleValid)
		else $error("clockRecovery: nibble strobe longer than one cycle");

endmodule

`default_nettype wire

//--- rtl/phaseDetector.sv
`timescale 1ns/1ps
`default_nettype none

module phaseDetector (
	input  wire               i_clock,
	input  wire               i_rstN,
	input  wire mskPkg::iqSample_t i_sample,
	input  wire               i_valid,
	output logic              o_dir,
	output logic              o_dirValid
);
	import mskPkg::*;

	iqSample_t         prevSample;
	logic              havePrev;
	logic signed [7:0] prodIQ;
	logic signed [7:0] prodQI;
	logic signed [8:0] crossProd;

	////////////////////////////////////////
	// Rotation sign
	////////////////////////////////////////

	// Cross product prev x new, positive for a forward turn
	assign prodIQ    = prevSample.sinI * i_sample.sinQ;
	assign prodQI    = prevSample.sinQ * i_sample.sinI;
	assign crossProd = prodIQ - prodQI;

	always_ff @(posedge i_clock or negedge i_rstN) begin
		if (!i_rstN) begin
			havePrev   <= 1'b0;
			o_dirValid <= 1'b0;
			o_dir      <= 1'b0;
		end else begin
			// A gap breaks the chain, so the next sample only primes it
			havePrev   <= i_valid;
			o_dirValid <= i_valid && havePrev;
			if (i_valid && havePrev) begin
				o_dir <= (crossProd > 9'sd0);
			end
		end
	end

	// Previous sample
	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			prevSample <= i_sample;
		end
	end

endmodule

`default_nettype wire

//--- rtl/mskModulator.sv
`timescale 1ns/1ps
`default_nettype none

module mskModulator #(
	parameter int SAMPLES_PER_BIT = 4
) (
	input  wire               i_clock,
	input  wire               i_rstN,
	input  wire               i_fifoEmpty,
	input  wire mskPkg::nibble_t i_fifoData,
	output logic              o_fifoRdEn,
	output mskPkg::iqSample_t o_sample,
	output logic              o_valid,
	output logic              o_busy
);
	import mskPkg::*;

	// One slot per sample of a nibble
	localparam int SLOT_W = $clog2(4 * SAMPLES_PER_BIT);
	localparam logic [SLOT_W-1:0] LAST_SLOT  = SLOT_W'(4 * SAMPLES_PER_BIT - 1);
	localparam logic [SLOT_W-1:0] FETCH_SLOT = SLOT_W'(4 * SAMPLES_PER_BIT - 2);
	localparam logic [SLOT_W-1:0] BIT_MASK   = SLOT_W'(SAMPLES_PER_BIT - 1);
	localparam phase_t PHASE_STEP = phase_t'(QUARTER_STEPS / SAMPLES_PER_BIT);
	localparam phase_t COS_OFFSET = phase_t'(QUARTER_STEPS);

	logic              active;
	logic              fetchPending;
	nibble_t           shiftReg;
	logic [SLOT_W-1:0] slotCnt;
	phase_t            phase;
	phase_t            phaseNext;
	phase_t            cosIdx;
	logic              bitEnd;
	logic              lastSlot;

	assign bitEnd   = (slotCnt & BIT_MASK) == BIT_MASK;
	assign lastSlot = (slotCnt == LAST_SLOT);

	// Fetch when idle, or one slot before the end so the next nibble follows without a gap
	assign o_fifoRdEn = !i_fifoEmpty && !fetchPending && (!active || slotCnt == FETCH_SLOT);

	// Ones turn the wheel forward, zeros back
	assign phaseNext = shiftReg[3] ? phase + PHASE_STEP : phase - PHASE_STEP;
	assign cosIdx    = phaseNext + COS_OFFSET;

	always_ff @(posedge i_clock or negedge i_rstN) begin
		if (!i_rstN) begin
			active       <= 1'b0;
			fetchPending <= 1'b0;
			slotCnt      <= '0;
			phase        <= '0;
			o_valid      <= 1'b0;
		end else begin
			fetchPending <= o_fifoRdEn;
			o_valid      <= active;
			if (active) begin
				phase   <= phaseNext;
				slotCnt <= slotCnt + SLOT_W'(1);
				// Stop at the nibble end unless the next one is already here
				if (lastSlot) begin
					active <= fetchPending;
				end
			end else if (fetchPending) begin
				active  <= 1'b1;
				slotCnt <= '0;
			end
		end
	end

	// Bit shifter, MSB first, and the sample register
	always_ff @(posedge i_clock) begin
		if (fetchPending && (!active || lastSlot)) begin
			shiftReg <= i_fifoData;
		end else if (active && bitEnd) begin
			shiftReg <= {shiftReg[2:0], 1'b0};
		end
		if (active) begin
			o_sample.sinI <= SIN_TABLE[cosIdx];
			o_sample.sinQ <= SIN_TABLE[phaseNext];
		end
	end

	// Busy while samples stream out
	assign o_busy = o_valid;

	aNoEmptyRead: assert property (@(posedge i_clock) disable iff (!i_rstN)
		o_fifoRdEn |-> !i_fifoEmpty)
		else $error("mskModulator: FIFO read while empty");

endmodule

`default_nettype wire

//--- rtl/nibbleFifo.sv
`timescale 1ns/1ps
`default_nettype none

module nibbleFifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  wire             i_clock,
	input  wire             i_rstN,
	input  wire             i_wrEn,
	input  wire mskPkg::nibble_t i_wrData,
	input  wire             i_rdEn,
	output mskPkg::nibble_t o_rdData,
	output logic            o_empty,
	output logic            o_full
);
	import mskPkg::*;

	localparam int ADDR_W = $clog2(FIFO_DEPTH);
	localparam logic [ADDR_W:0] PTR_ONE   = (ADDR_W+1)'(1);
	localparam logic [ADDR_W:0] PTR_DEPTH = (ADDR_W+1)'(FIFO_DEPTH);

	nibble_t         mem [FIFO_DEPTH];
	// Top bit of each pointer is the wrap flag
	logic [ADDR_W:0] wrPtr;
	logic [ADDR_W:0] rdPtr;
	logic [ADDR_W:0] fillLevel;
	logic            doWrite;
	logic            doRead;

	assign o_empty   = (wrPtr == rdPtr);
	assign o_full    = (wrPtr[ADDR_W] != rdPtr[ADDR_W]) &&
	                   (wrPtr[ADDR_W-1:0] == rdPtr[ADDR_W-1:0]);
	assign fillLevel = wrPtr - rdPtr;

	// Writes into a full FIFO and reads from an empty one are dropped
	assign doWrite = i_wrEn && !o_full;
	assign doRead  = i_rdEn && !o_empty;

	always_ff @(posedge i_clock or negedge i_rstN) begin
		if (!i_rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
		end else begin
			if (doWrite) begin
				wrPtr <= wrPtr + PTR_ONE;
			end
			if (doRead) begin
				rdPtr <= rdPtr + PTR_ONE;
			end
		end
	end

	// Storage and read port
	always_ff @(posedge i_clock) begin
		if (doWrite) begin
			mem[wrPtr[ADDR_W-1:0]] <= i_wrData;
		end
		if (doRead) begin
			o_rdData <= mem[rdPtr[ADDR_W-1:0]];
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	aWrWhileFull: assert property (@(posedge i_clock) disable iff (!i_rstN)
		!(i_wrEn && o_full))
		else $warning("nibbleFifo: write while full was dropped");

	aRdWhileEmpty: assert property (@(posedge i_clock) disable iff (!i_rstN)
		!(i_rdEn && o_empty))
		else $warning("nibbleFifo: read while empty was ignored");

	aFillLevel: assert property (@(posedge i_clock) disable iff (!i_rstN)
		fillLevel <= PTR_DEPTH)
		else $error("nibbleFifo: pointer distance above depth");

endmodule

`default_nettype wire

//--- rtl/mskPkg.sv
`default_nettype none

package mskPkg;

	////////////////////////////////////////
	// Data words
	////////////////////////////////////////

	// Payload of both FIFOs
	typedef logic [3:0] nibble_t;

	// One complex baseband sample, two's complement
	typedef struct packed {
		logic signed [3:0] sinI;
		logic signed [3:0] sinQ;
	} iqSample_t;

	// Live flags of the modem, as seen on the observation port
	typedef struct packed {
		logic       inEmpty;
		logic       outFull;
		logic       txBusy;
		logic       dir;
		logic       bitValid;
		logic       testMode;
		logic [1:0] spare;
	} modStatus_t;

	// One observation byte, read as a sample or as status
	typedef union packed {
		iqSample_t  sample;
		modStatus_t status;
	} obsWord_t;

	// Observation port select
	typedef enum logic [1:0] {
		OBS_MOD_IQ     = 2'd0,
		OBS_ADC_IQ     = 2'd1,
		OBS_STATUS     = 2'd2,
		OBS_OUT_NIBBLE = 2'd3
	} obsSel_t;

	////////////////////////////////////////
	// Phase wheel
	////////////////////////////////////////

	localparam int PHASE_STEPS   = 16;
	// A bit turns the carrier by a quarter of the wheel
	localparam int QUARTER_STEPS = PHASE_STEPS / 4;

	typedef logic [$clog2(PHASE_STEPS)-1:0] phase_t;

	// Sine scaled to +-7, cosine sits a quarter turn ahead
	localparam logic signed [3:0] SIN_TABLE [PHASE_STEPS] = '{
		4'sd0,  4'sd3,  4'sd5,  4'sd6,
		4'sd7,  4'sd6,  4'sd5,  4'sd3,
		4'sd0,  -4'sd3, -4'sd5, -4'sd6,
		-4'sd7, -4'sd6, -4'sd5, -4'sd3
	};

endpackage

`default_nettype wire
